// File: source/exe_pkg.sv
// widths, thread count, register and pc types, opcode and branch-mode enums

package exe_pkg;

    // ------------------------------------------------
    // widths
    // ------------------------------------------------

    localparam int XLEN       = 32;
    localparam int THREADS    = 4;
    localparam int ID_BITS    = $clog2(THREADS);
    localparam int SHAMT_BITS = $clog2(XLEN);
    localparam int PC_BITS    = 32;

    // ------------------------------------------------
    // value types
    // ------------------------------------------------

    typedef logic [XLEN-1:0]    rval_t;
    typedef logic [PC_BITS-1:0] pc_t;
    typedef logic [ID_BITS-1:0] id_t;

    // x0..x31
    typedef logic [4:0]         ridx_t;

    // ------------------------------------------------
    // operation kind
    // ------------------------------------------------

    // alu ops first, branch last
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_SLL    = 4'd5,
        OP_SRL    = 4'd6,
        OP_SRA    = 4'd7,
        OP_BRANCH = 4'd8
    } exe_op_e;

    // ------------------------------------------------
    // branch mode
    // ------------------------------------------------

    // conditional modes follow the rv32 funct3 codes,
    // jal and jalr sit in the two codes funct3 leaves free
    typedef enum logic [2:0] {
        BR_EQ   = 3'd0,
        BR_NE   = 3'd1,
        BR_JAL  = 3'd2,
        BR_JALR = 3'd3,
        BR_LT   = 3'd4,
        BR_GE   = 3'd5,
        BR_LTU  = 3'd6,
        BR_GEU  = 3'd7
    } br_mode_e;

endpackage

// File: source/exe_alu.sv
// alu path with operand select, add/sub, logical ops, shifts and result register
`timescale 1ns/10ps

module exe_alu (
    input  logic             clk,

    input  exe_pkg::exe_op_e issue_op,
    input  exe_pkg::rval_t   rs1_val,
    input  exe_pkg::rval_t   rs2_val,
    input  logic             imm_en,
    input  exe_pkg::rval_t   imm_val,

    output exe_pkg::rval_t   alu_val
);

    import exe_pkg::*;

    rval_t                 op_b;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  sub;
    rval_t                 sum;
    rval_t                 logic_val;
    rval_t                 shift_val;
    rval_t                 result;

    // ------------------------------------------------
    // operand b
    // ------------------------------------------------

    assign op_b  = imm_en ? imm_val : rs2_val;

    // rv32 uses only the low five bits
    assign shamt = op_b[SHAMT_BITS-1:0];

    // ------------------------------------------------
    // adder
    // ------------------------------------------------

    // one adder, subtract by inverted b plus carry in
    assign sub = (issue_op == OP_SUB);
    assign sum = rs1_val + (sub ? ~op_b : op_b) + rval_t'(sub);

    // ------------------------------------------------
    // logical and shift
    // ------------------------------------------------

    always_comb begin
        case (issue_op)
            OP_AND:  logic_val = rs1_val & op_b;
            OP_OR:   logic_val = rs1_val | op_b;
            default: logic_val = rs1_val ^ op_b;
        endcase
    end

    always_comb begin
        case (issue_op)
            OP_SLL:  shift_val = rs1_val << shamt;
            OP_SRL:  shift_val = rs1_val >> shamt;
            default: shift_val = rval_t'($signed(rs1_val) >>> shamt);
        endcase
    end

    // ------------------------------------------------
    // result select
    // ------------------------------------------------

    // branch ops fall through to the sum
    always_comb begin
        case (issue_op)
            OP_AND,
            OP_OR,
            OP_XOR:  result = logic_val;
            OP_SLL,
            OP_SRL,
            OP_SRA:  result = shift_val;
            default: result = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        alu_val <= result;
    end

endmodule

// File: source/exe_branch_cond.sv
// branch path with operand compares, taken decision, target select and link value
`timescale 1ns/10ps

module exe_branch_cond (
    input  logic              clk,

    input  exe_pkg::pc_t      issue_pc,
    input  exe_pkg::rval_t    rs1_val,
    input  exe_pkg::rval_t    rs2_val,
    input  exe_pkg::rval_t    imm_val,
    input  exe_pkg::br_mode_e br_mode,
    input  exe_pkg::pc_t      br_pc,

    output logic              br_taken,
    output exe_pkg::pc_t      br_target,
    output exe_pkg::rval_t    link_val
);

    import exe_pkg::*;

    logic  eq;
    logic  lt;
    logic  ltu;
    logic  taken;
    rval_t jalr_sum;
    pc_t   target;
    pc_t   link_pc;

    // ------------------------------------------------
    // compares
    // ------------------------------------------------

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    always_comb begin
        case (br_mode)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt;
            BR_GE:   taken = !lt;
            BR_LTU:  taken = ltu;
            BR_GEU:  taken = !ltu;
            // jal, jalr
            default: taken = 1'b1;
        endcase
    end

    // ------------------------------------------------
    // target and link
    // ------------------------------------------------

    assign jalr_sum = rs1_val + imm_val;

    // jalr clears bit 0 of the sum
    assign target = (br_mode == BR_JALR) ? {jalr_sum[PC_BITS-1:1], 1'b0} : br_pc;

    assign link_pc = issue_pc + pc_t'(4);

    // ------------------------------------------------
    // output register
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        br_taken  <= taken;
        br_target <= target;
        link_val  <= rval_t'(link_pc);
    end

endmodule

// File: source/exe_retire.sv
// stage-0 control register, per-thread phase table, writeback and redirect outputs
`timescale 1ns/10ps

module exe_retire (
    input  logic             clk,
    input  logic             reset,

    input  logic             issue_valid,
    input  exe_pkg::id_t     issue_id,
    input  logic             issue_phase,
    input  exe_pkg::exe_op_e issue_op,
    input  logic             issue_rd_en,
    input  exe_pkg::ridx_t   issue_rd_idx,

    input  exe_pkg::rval_t   alu_val,
    input  logic             br_taken,
    input  exe_pkg::pc_t     br_target,
    input  exe_pkg::rval_t   link_val,

    output logic             wb_valid,
    output exe_pkg::id_t     wb_id,
    output exe_pkg::ridx_t   wb_rd_idx,
    output exe_pkg::rval_t   wb_val,

    output logic             branch_valid,
    output exe_pkg::id_t     branch_id,
    output exe_pkg::pc_t     branch_pc
);

    import exe_pkg::*;

    logic               st0_valid;
    id_t                st0_id;
    logic               st0_phase;
    exe_op_e            st0_op;
    logic               st0_rd_en;
    ridx_t              st0_rd_idx;

    logic [THREADS-1:0] phase_table;
    logic               st0_live;
    logic               st0_redirect;
    logic               st0_write;

    // ------------------------------------------------
    // stage 0
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
        end else begin
            st0_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        st0_id     <= issue_id;
        st0_phase  <= issue_phase;
        st0_op     <= issue_op;
        st0_rd_en  <= issue_rd_en;
        st0_rd_idx <= issue_rd_idx;
    end

    // stale phase means an older taken branch of this thread redirected it
    assign st0_live     = st0_valid && (st0_phase == phase_table[st0_id]);
    assign st0_redirect = st0_live && (st0_op == OP_BRANCH) && br_taken;
    assign st0_write    = st0_live && st0_rd_en;

    // ------------------------------------------------
    // phase table
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_table <= '0;
        end else if (st0_redirect) begin
            phase_table[st0_id] <= !phase_table[st0_id];
        end
    end

    // ------------------------------------------------
    // outputs
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid     <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            wb_valid     <= st0_write;
            branch_valid <= st0_redirect;
        end
    end

    always_ff @(posedge clk) begin
        wb_id     <= st0_id;
        wb_rd_idx <= st0_rd_idx;
        // branches write back pc + 4
        wb_val    <= (st0_op == OP_BRANCH) ? link_val : alu_val;
        branch_id <= st0_id;
        branch_pc <= br_target;
    end

endmodule

// File: source/exe_unit.sv
// execute stage top joining the alu path, branch path and retire logic
`timescale 1ns/10ps

module exe_unit (
    input  logic              clk,
    input  logic              reset,

    input  logic              issue_valid,
    input  exe_pkg::id_t      issue_id,
    input  logic              issue_phase,
    input  exe_pkg::pc_t      issue_pc,
    input  exe_pkg::exe_op_e  issue_op,
    input  logic              issue_rd_en,
    input  exe_pkg::ridx_t    issue_rd_idx,
    input  exe_pkg::rval_t    rs1_val,
    input  exe_pkg::rval_t    rs2_val,
    input  logic              imm_en,
    input  exe_pkg::rval_t    imm_val,
    input  exe_pkg::br_mode_e br_mode,
    input  exe_pkg::pc_t      br_pc,

    output logic              wb_valid,
    output exe_pkg::id_t      wb_id,
    output exe_pkg::ridx_t    wb_rd_idx,
    output exe_pkg::rval_t    wb_val,

    output logic              branch_valid,
    output exe_pkg::id_t      branch_id,
    output exe_pkg::pc_t      branch_pc
);

    import exe_pkg::*;

    rval_t alu_val;
    logic  br_taken;
    pc_t   br_target;
    rval_t link_val;

    exe_alu u_alu (
        .clk      (clk),
        .issue_op (issue_op),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .imm_en   (imm_en),
        .imm_val  (imm_val),
        .alu_val  (alu_val)
    );

    // computes taken for every op, retire qualifies it
    exe_branch_cond u_branch_cond (
        .clk       (clk),
        .issue_pc  (issue_pc),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .imm_val   (imm_val),
        .br_mode   (br_mode),
        .br_pc     (br_pc),
        .br_taken  (br_taken),
        .br_target (br_target),
        .link_val  (link_val)
    );

    exe_retire u_retire (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_id     (issue_id),
        .issue_phase  (issue_phase),
        .issue_op     (issue_op),
        .issue_rd_en  (issue_rd_en),
        .issue_rd_idx (issue_rd_idx),
        .alu_val      (alu_val),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .link_val     (link_val),
        .wb_valid     (wb_valid),
        .wb_id        (wb_id),
        .wb_rd_idx    (wb_rd_idx),
        .wb_val       (wb_val),
        .branch_valid (branch_valid),
        .branch_id    (branch_id),
        .branch_pc    (branch_pc)
    );

endmodule

// File: test/exe_unit_tb.sv
// exe_unit testbench with clock, reset, file-driven cases, compare tasks, watchdog and summary
`timescale 1ns/10ps

module exe_unit_tb;

    import exe_pkg::*;

    localparam int MAX_CASES = 128;
    localparam int FIELDS    = 18;

    typedef struct packed {
        logic  wb_valid;
        id_t   wb_id;
        ridx_t wb_rd_idx;
        rval_t wb_val;
        logic  branch_valid;
        id_t   branch_id;
        pc_t   branch_pc;
    } expect_t;

    logic     clk;
    logic     reset;

    logic     issue_valid;
    id_t      issue_id;
    logic     issue_phase;
    pc_t      issue_pc;
    exe_op_e  issue_op;
    logic     issue_rd_en;
    ridx_t    issue_rd_idx;
    rval_t    rs1_val;
    rval_t    rs2_val;
    logic     imm_en;
    rval_t    imm_val;
    br_mode_e br_mode;
    pc_t      br_pc;

    logic     wb_valid;
    id_t      wb_id;
    ridx_t    wb_rd_idx;
    rval_t    wb_val;
    logic     branch_valid;
    id_t      branch_id;
    pc_t      branch_pc;

    // one row per case with the fields in file column order
    logic [31:0] cases [MAX_CASES][FIELDS];
    int          num_cases;
    logic        cases_loaded;
    expect_t     exp_q[$];

    int wb_errors;
    int branch_errors;
    int flag_errors;

    exe_unit dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------
    // compare tasks
    // ------------------------------------------------

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_wb(input id_t got_id, input id_t exp_id, input ridx_t got_rd,
                            input ridx_t exp_rd, input rval_t got_val, input rval_t exp_val);
        if (got_id !== exp_id) begin
            wb_errors++;
            $display("[ERROR] wb_id got %h expected %h at %0t", got_id, exp_id, $time);
        end
        if (got_rd !== exp_rd) begin
            wb_errors++;
            $display("[ERROR] wb_rd_idx got %h expected %h at %0t", got_rd, exp_rd, $time);
        end
        if (got_val !== exp_val) begin
            wb_errors++;
            $display("[ERROR] wb_val got %h expected %h at %0t", got_val, exp_val, $time);
        end
    endtask

    task automatic check_branch(input id_t got_id, input id_t exp_id,
                                input pc_t got_pc, input pc_t exp_pc);
        if (got_id !== exp_id) begin
            branch_errors++;
            $display("[ERROR] branch_id got %h expected %h at %0t", got_id, exp_id, $time);
        end
        if (got_pc !== exp_pc) begin
            branch_errors++;
            $display("[ERROR] branch_pc got %h expected %h at %0t", got_pc, exp_pc, $time);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_flag("wb_valid", wb_valid, e.wb_valid);
        if (e.wb_valid && wb_valid) begin
            check_wb(wb_id, e.wb_id, wb_rd_idx, e.wb_rd_idx, wb_val, e.wb_val);
        end
        check_flag("branch_valid", branch_valid, e.branch_valid);
        if (e.branch_valid && branch_valid) begin
            check_branch(branch_id, e.branch_id, branch_pc, e.branch_pc);
        end
    endtask

    // ------------------------------------------------
    // stimulus
    // ------------------------------------------------

    // check the case driven two cycles back and queue the new one
    task automatic next_cycle(input expect_t e);
        @(negedge clk);
        if (exp_q.size() == 2) begin
            check_outputs(exp_q.pop_front());
        end
        exp_q.push_back(e);
    endtask

    task automatic drive_idle();
        next_cycle('0);
        issue_valid  = 1'b0;
        issue_id     = '0;
        issue_phase  = 1'b0;
        issue_pc     = '0;
        issue_op     = OP_ADD;
        issue_rd_en  = 1'b0;
        issue_rd_idx = '0;
        rs1_val      = '0;
        rs2_val      = '0;
        imm_en       = 1'b0;
        imm_val      = '0;
        br_mode      = BR_EQ;
        br_pc        = '0;
    endtask

    task automatic drive_case(input int i);
        expect_t e;
        e.wb_valid     = cases[i][14][0];
        e.wb_id        = cases[i][2][ID_BITS-1:0];
        e.wb_rd_idx    = cases[i][7][4:0];
        e.wb_val       = cases[i][15];
        e.branch_valid = cases[i][16][0];
        e.branch_id    = cases[i][2][ID_BITS-1:0];
        e.branch_pc    = cases[i][17];
        next_cycle(e);
        issue_valid  = cases[i][1][0];
        issue_id     = cases[i][2][ID_BITS-1:0];
        issue_phase  = cases[i][3][0];
        issue_pc     = cases[i][4];
        issue_op     = exe_op_e'(cases[i][5][3:0]);
        issue_rd_en  = cases[i][6][0];
        issue_rd_idx = cases[i][7][4:0];
        rs1_val      = cases[i][8];
        rs2_val      = cases[i][9];
        imm_en       = cases[i][10][0];
        imm_val      = cases[i][11];
        br_mode      = br_mode_e'(cases[i][12][2:0]);
        br_pc        = cases[i][13];
    endtask

    task automatic load_cases();
        int          fd;
        int          code;
        logic [31:0] f [FIELDS];
        logic [8*256-1:0] line;
        fd = $fopen("test/exe_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                code = $fgets(line, fd);
                // comment and blank lines do not give all the fields
                if (code > 0) begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                   f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                    if (code == FIELDS) begin
                        for (int k = 0; k < FIELDS; k++) begin
                            cases[num_cases][k] = f[k];
                        end
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
        end
        cases_loaded = 1'b1;
    endtask

    // ------------------------------------------------
    // main sequence
    // ------------------------------------------------

    initial begin
        int seed;
        int gap;
        num_cases     = 0;
        cases_loaded  = 1'b0;
        wb_errors     = 0;
        branch_errors = 0;
        flag_errors   = 0;
        seed          = $urandom(32'h09f1_cd46);
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue_id      = '0;
        issue_phase   = 1'b0;
        issue_pc      = '0;
        issue_op      = OP_ADD;
        issue_rd_en   = 1'b0;
        issue_rd_idx  = '0;
        rs1_val       = '0;
        rs2_val       = '0;
        imm_en        = 1'b0;
        imm_val       = '0;
        br_mode       = BR_EQ;
        br_pc         = '0;
        load_cases();
        if (num_cases == 0) begin
            $display("no cases could be read from test/exe_cases.txt");
            $display("Checks failed");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            // quiet outputs after reset
            repeat (4) drive_idle();
            for (int i = 0; i < num_cases; i++) begin
                if (cases[i][0][0] && i > 0) begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) drive_idle();
                end
                drive_case(i);
            end
            repeat (3) drive_idle();
            $display("errors: wb %0d, branch %0d, flag %0d",
                     wb_errors, branch_errors, flag_errors);
            if (wb_errors + branch_errors + flag_errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (cases_loaded);
        #((num_cases * 3 + 20) * 10);
        $display("timeout: the cases did not finish in the expected time");
        $display("Checks failed");
        $finish;
    end

endmodule

// File: test/exe_cases.txt
# grp valid id phase pc op rd_en rd rs1 rs2 imm_en imm mode br_pc | wb_valid wb_val br_valid br_pc
# hex; grp 1 allows random idle cycles before the line, grp 0 keeps it back-to-back
# alu ops, thread 0 and 2
1 1 0 0 00000100 0 1 01 00000005 00000007 0 00000000 0 00000000 1 0000000c 0 00000000
1 1 0 0 00000104 0 1 02 00000010 00000003 1 fffffff0 0 00000000 1 00000000 0 00000000
1 1 0 0 00000108 1 1 03 00000005 00000007 0 00000000 0 00000000 1 fffffffe 0 00000000
1 1 0 0 0000010c 1 1 04 00000100 deadbeef 1 00000001 0 00000000 1 000000ff 0 00000000
1 1 0 0 00000110 2 1 05 f0f0f0f0 ff00ff00 0 00000000 0 00000000 1 f000f000 0 00000000
1 1 0 0 00000114 3 1 06 12340000 00005678 0 00000000 0 00000000 1 12345678 0 00000000
1 1 0 0 00000118 4 1 07 aaaaaaaa ffffffff 0 00000000 0 00000000 1 55555555 0 00000000
1 1 0 0 0000011c 4 1 08 0000ffff 12345678 1 0000f0f0 0 00000000 1 00000f0f 0 00000000
1 1 0 0 00000120 5 1 09 00000001 0000001f 0 00000000 0 00000000 1 80000000 0 00000000
1 1 0 0 00000124 5 1 0a 00000003 ffffffff 1 00000024 0 00000000 1 00000030 0 00000000
1 1 0 0 00000128 6 1 0b 80000000 00000004 0 00000000 0 00000000 1 08000000 0 00000000
1 1 0 0 0000012c 7 1 0c 80000000 00000004 0 00000000 0 00000000 1 f8000000 0 00000000
1 1 0 0 00000130 7 1 0d 7fff0000 00000000 1 00000010 0 00000000 1 00007fff 0 00000000
1 1 0 0 00000134 0 0 0e 00000001 00000001 0 00000000 0 00000000 0 00000000 0 00000000
1 1 2 0 00000200 0 1 1f 00000001 00000001 0 00000000 0 00000000 1 00000002 0 00000000
# conditional branches, threads 1 and 3 alternate
1 1 1 0 00000300 8 0 00 00000005 00000005 0 00000000 0 00001000 0 00000000 1 00001000
1 1 3 0 00000304 8 0 00 00000005 00000006 0 00000000 0 00001004 0 00000000 0 00000000
1 1 1 1 00000308 8 0 00 00000005 00000005 0 00000000 1 00001008 0 00000000 0 00000000
1 1 3 0 0000030c 8 0 00 00000005 00000006 0 00000000 1 00001100 0 00000000 1 00001100
1 1 1 1 00000310 8 0 00 ffffffff 00000001 0 00000000 4 00002000 0 00000000 1 00002000
1 1 3 1 00000314 8 0 00 ffffffff 00000001 0 00000000 6 00002004 0 00000000 0 00000000
1 1 1 0 00000318 8 0 00 ffffffff 00000001 0 00000000 5 00002008 0 00000000 0 00000000
1 1 3 1 0000031c 8 0 00 ffffffff 00000001 0 00000000 7 00002100 0 00000000 1 00002100
1 1 1 0 00000320 8 0 00 00000005 00000005 0 00000000 5 00002200 0 00000000 1 00002200
1 1 3 0 00000324 8 0 00 00000001 ffffffff 0 00000000 4 00002204 0 00000000 0 00000000
1 1 1 1 00000328 8 0 00 00000001 00000002 0 00000000 6 00002300 0 00000000 1 00002300
1 1 3 0 0000032c 8 0 00 00000001 00000002 0 00000000 7 00002304 0 00000000 0 00000000
# jal and jalr
1 1 0 0 00000400 8 1 01 00000000 00000000 0 00000000 2 00000800 1 00000404 1 00000800
1 1 2 0 00000500 8 1 05 00001001 00000000 0 00000020 3 00000000 1 00000504 1 00001020
1 1 0 1 00000600 8 0 02 00000000 00000000 0 00000000 2 00000900 0 00000000 1 00000900
1 1 2 1 00000700 8 1 06 00002000 00000000 0 fffffffc 3 00000000 1 00000704 1 00001ffc
# phase kill on thread 0
1 1 0 0 00000a00 8 0 00 00000000 00000000 0 00000000 0 0000a000 0 00000000 1 0000a000
0 1 0 0 00000a04 0 1 03 00000001 00000001 0 00000000 0 00000000 0 00000000 0 00000000
0 1 0 1 0000a000 0 1 04 00000002 00000002 0 00000000 0 00000000 1 00000004 0 00000000
1 1 0 1 0000a004 8 0 00 00000000 00000000 0 00000000 0 0000b000 0 00000000 1 0000b000
0 1 0 1 0000a008 8 0 00 00000001 00000002 0 00000000 1 0000a800 0 00000000 0 00000000
0 1 0 0 0000b000 0 1 07 00000003 00000004 0 00000000 0 00000000 1 00000007 0 00000000
# kills on thread 1 interleaved with threads 2 and 3
1 1 1 0 00000c00 8 0 00 00000000 00000000 0 00000000 0 0000c000 0 00000000 1 0000c000
0 1 2 0 00000c04 0 1 08 00000010 00000020 0 00000000 0 00000000 1 00000030 0 00000000
0 1 1 0 00000c08 0 1 09 00000005 00000005 0 00000000 0 00000000 0 00000000 0 00000000
0 1 1 1 0000c000 0 1 09 00000005 00000006 0 00000000 0 00000000 1 0000000b 0 00000000
0 1 3 0 00000d00 4 1 0a 000000ff 0000000f 0 00000000 0 00000000 1 000000f0 0 00000000
1 1 1 1 0000c004 8 0 00 00000001 00000002 0 00000000 1 0000d000 0 00000000 1 0000d000
0 1 1 1 0000c008 1 1 0b 00000009 00000001 0 00000000 0 00000000 0 00000000 0 00000000
0 1 3 0 00000d04 0 1 0c 00000002 00000003 0 00000000 0 00000000 1 00000005 0 00000000
0 1 1 0 0000d000 3 1 0d 000000f0 0000000f 0 00000000 0 00000000 1 000000ff 0 00000000

// File: tb.f
source/exe_pkg.sv
source/exe_alu.sv
source/exe_branch_cond.sv
source/exe_retire.sv
source/exe_unit.sv
test/exe_unit_tb.sv
